/* common/prf_config.svh */
`ifndef PRF_CONFIG_SVH
`define PRF_CONFIG_SVH

//////////////////////////////
// register file geometry
//////////////////////////////

// number of physical registers shared by both threads
`define PRF_SIZE 32

// width of one register value
`define PRF_DATA_W 64

// width of an entry index
// tracks PRF_SIZE so that a resize only touches the line above
`define PRF_TAG_W $clog2(`PRF_SIZE)

`endif

/* common/prf_pkg.sv */
`default_nettype none

`include "prf_config.svh"

package prf_pkg;

	typedef logic [`PRF_TAG_W-1:0]  prf_tag_t;	// index of one physical register
	typedef logic [`PRF_SIZE-1:0]   prf_vec_t;	// one bit per physical register
	typedef logic [`PRF_DATA_W-1:0] prf_data_t;	// value held by one register

	// result broadcast from the common data bus
	typedef struct packed {
		logic      valid;
		prf_tag_t  tag;	// destination register of the result
		prf_data_t data;
	} cdb_t;

	// answer to one rename request
	typedef struct packed {
		logic     valid;	// low when the request lost out or the pool ran dry
		prf_tag_t tag;
	} alloc_grant_t;

	typedef struct packed {
		prf_tag_t tag;	// register holding the operand
	} rd_req_t;

	typedef struct packed {
		logic      valid;	// the operand has been produced
		prf_data_t data;	// zero whenever valid is low
	} rd_rsp_t;

	// single register released when an instruction retires
	typedef struct packed {
		logic     valid;
		prf_tag_t tag;
	} retire_free_t;

	// bulk release when one thread recovers from a mispredict
	typedef struct packed {
		logic     valid;
		prf_vec_t rrat_free_list;	// candidates from this thread's retirement table
		prf_vec_t rat_free_list;	// registers the other thread's rename table does not hold
	} flush_free_t;

endpackage

`default_nettype wire

/* prf/prf_one_entry.sv */
`default_nettype none
`timescale 1ns/1ps

module prf_one_entry
	import prf_pkg::*;
(
	input  logic      clock,
	input  logic      rst_n,
	input  logic      free_this_entry,	// retire or flush releases this register
	input  logic      assign_a_free_reg,	// rename claims this register
	input  logic      write_prf_enable,	// a data bus broadcast targets this register
	input  prf_data_t data_in,
	output logic      prf_available,	// high while the register sits in the free pool
	output logic      prf_ready,	// high once the producer has written its result
	output prf_data_t data_out
);

	// flag update, free beats allocate and allocate beats write
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prf_available <= 1'b1;	// every register starts in the free pool
			prf_ready     <= 1'b0;
		end
		else if (free_this_entry)
		begin
			prf_available <= 1'b1;
			prf_ready     <= 1'b0;	// a released value must never be forwarded again
		end
		else if (assign_a_free_reg)
		begin
			// the new producer has not executed yet
			prf_available <= 1'b0;
			prf_ready     <= 1'b0;
		end
		else if (write_prf_enable)
		begin
			prf_ready <= 1'b1;	// operands waiting on this tag may now issue
		end
	end

	// the value only moves when the flags say a write really took effect
	always_ff @(posedge clock)
	begin
		if (write_prf_enable && !free_this_entry && !assign_a_free_reg)
		begin
			data_out <= data_in;
		end
	end

	// a result can only target a register that rename handed out in an earlier cycle
	a_no_write_to_free: assert property (@(posedge clock) disable iff (!rst_n)
		write_prf_enable |-> !prf_available)
		else $error("prf_one_entry: data bus write to a register in the free pool");

endmodule

`default_nettype wire

/* prf/priority_selector.sv */
`default_nettype none
`timescale 1ns/1ps

module priority_selector #(
	parameter int WIDTH = 32	// number of request lines
) (
	input  logic [WIDTH-1:0] req,	// one bit per candidate
	input  logic             en,	// no grant at all while low
	output logic [WIDTH-1:0] gnt	// one-hot, lowest set request wins
);

	logic found;	// a lower bit has already taken the grant

	always_comb
	begin
		gnt   = '0;
		found = 1'b0;
		// scan upward so bit 0 has the highest priority
		for (int i = 0; i < WIDTH; i++)
		begin
			if (en && req[i] && !found)
			begin
				gnt[i] = 1'b1;
				found  = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* prf/prf_read_port.sv */
`default_nettype none
`timescale 1ns/1ps

`include "prf_config.svh"

module prf_read_port
	import prf_pkg::*;
(
	input  rd_req_t                   req,	// operand tag from dispatch
	input  prf_vec_t                  prf_available,	// free flags of all entries
	input  prf_vec_t                  prf_ready,	// written flags of all entries
	input  prf_data_t [`PRF_SIZE-1:0] data_all,	// values of all entries
	output rd_rsp_t                   rsp
);

	logic hit;	// addressed register is in use and already written

	// a free register may still carry a stale ready flag, so both flags are checked
	assign hit = prf_ready[req.tag] && !prf_available[req.tag];

	assign rsp.valid = hit;
	assign rsp.data  = hit ? data_all[req.tag] : '0;	// dispatch waits on the tag otherwise

endmodule

`default_nettype wire

/* prf/prf.sv */
`default_nettype none
`timescale 1ns/1ps

`include "prf_config.svh"

module prf
	import prf_pkg::*;
(
	input  logic               clock,
	input  logic               rst_n,
	input  logic [3:0]         alloc_req,	// bit 0 thread0 slot0 up to bit 3 thread1 slot1
	output alloc_grant_t [3:0] grant,	// same order as alloc_req
	input  cdb_t               cdb1,
	input  cdb_t               cdb2,	// wins over cdb1 on a shared tag
	input  rd_req_t [3:0]      rd_req,	// inst1 a, inst1 b, inst2 a, inst2 b
	output rd_rsp_t [3:0]      rd_rsp,
	input  retire_free_t       retire1,
	input  retire_free_t       retire2,
	input  flush_free_t        flush1,	// recovery of thread 0
	input  flush_free_t        flush2	// recovery of thread 1
);

	prf_vec_t                  avail_vec;	// entries currently in the free pool
	prf_vec_t                  ready_vec;	// entries whose value has been written
	prf_vec_t                  gnt1;	// one-hot pick of the first selector
	prf_vec_t                  gnt2;	// one-hot pick of the second selector
	prf_vec_t                  sel2_req;
	prf_vec_t                  alloc_vec;
	prf_vec_t                  write_vec;
	prf_vec_t                  retire_vec;
	prf_vec_t                  flush_vec;
	prf_vec_t                  free_vec;
	prf_data_t [`PRF_SIZE-1:0] data_in_all;
	prf_data_t [`PRF_SIZE-1:0] data_out_all;
	logic                      sel1_en;
	logic                      sel2_en;
	logic                      valid1;
	logic                      valid2;
	prf_tag_t                  tag1;
	prf_tag_t                  tag2;

	// one-hot to index, yields zero for an empty vector
	function automatic prf_tag_t onehot_to_tag(input prf_vec_t vec);
		prf_tag_t tag;
		tag = '0;
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (vec[i])
			begin
				tag = tag | prf_tag_t'(i);
			end
		end
		return tag;
	endfunction

	//////////////////////////////
	// allocation
	//////////////////////////////

	// at most two registers leave the pool per cycle
	assign sel1_en = |alloc_req;
	assign sel2_en = ($countones(alloc_req) > 1);	// only when a second requester exists

	// the second selector must skip whatever the first one took
	assign sel2_req = avail_vec & ~gnt1;

	priority_selector #(.WIDTH(`PRF_SIZE)) u_sel1 (
		.req(avail_vec),
		.en (sel1_en),
		.gnt(gnt1)
	);

	priority_selector #(.WIDTH(`PRF_SIZE)) u_sel2 (
		.req(sel2_req),
		.en (sel2_en),
		.gnt(gnt2)
	);

	assign valid1    = |gnt1;	// low when the pool is empty
	assign valid2    = |gnt2;
	assign tag1      = onehot_to_tag(gnt1);
	assign tag2      = onehot_to_tag(gnt2);
	assign alloc_vec = gnt1 | gnt2;	// claimed entries drop out of the pool next edge

	// first asserted request takes selector 1, second takes selector 2, the rest get nothing
	always_comb
	begin
		int served;
		served = 0;
		for (int r = 0; r < 4; r++)
		begin
			grant[r] = '0;
			if (alloc_req[r])
			begin
				if (served == 0)
				begin
					grant[r].valid = valid1;
					grant[r].tag   = tag1;
				end
				else if (served == 1)
				begin
					grant[r].valid = valid2;
					grant[r].tag   = tag2;
				end
				served++;	// requesters beyond the second are dropped and retry
			end
		end
	end

	//////////////////////////////
	// writeback from the data bus
	//////////////////////////////

	always_comb
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			write_vec[i] = (cdb1.valid && cdb1.tag == prf_tag_t'(i)) ||
				(cdb2.valid && cdb2.tag == prf_tag_t'(i));
			// cdb2 takes priority when both buses name this entry
			if (cdb2.valid && cdb2.tag == prf_tag_t'(i))
			begin
				data_in_all[i] = cdb2.data;
			end
			else
			begin
				data_in_all[i] = cdb1.data;	// ignored by the entry unless write_vec is set
			end
		end
	end

	//////////////////////////////
	// release
	//////////////////////////////

	always_comb
	begin
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			retire_vec[i] = (retire1.valid && retire1.tag == prf_tag_t'(i)) ||
				(retire2.valid && retire2.tag == prf_tag_t'(i));
		end
	end

	// a thread may only release what the other thread's rename table no longer holds
	assign flush_vec = (flush1.valid ? (flush1.rrat_free_list & flush1.rat_free_list) : '0) |
		(flush2.valid ? (flush2.rrat_free_list & flush2.rat_free_list) : '0);

	assign free_vec = retire_vec | flush_vec;	// both sources may fire in the same cycle

	//////////////////////////////
	// storage and operand reads
	//////////////////////////////

	for (genvar i = 0; i < `PRF_SIZE; i++)
	begin : g_entry
		prf_one_entry u_entry (
			.clock            (clock),
			.rst_n            (rst_n),
			.free_this_entry  (free_vec[i]),
			.assign_a_free_reg(alloc_vec[i]),
			.write_prf_enable (write_vec[i]),
			.data_in          (data_in_all[i]),
			.prf_available    (avail_vec[i]),
			.prf_ready        (ready_vec[i]),
			.data_out         (data_out_all[i])
		);
	end

	// four operand ports, two per dispatching instruction
	for (genvar p = 0; p < 4; p++)
	begin : g_read
		prf_read_port u_read (
			.req          (rd_req[p]),
			.prf_available(avail_vec),
			.prf_ready    (ready_vec),
			.data_all     (data_out_all),
			.rsp          (rd_rsp[p])
		);
	end

	// two renamed destinations must never share one physical register
	a_grants_distinct: assert property (@(posedge clock) disable iff (!rst_n)
		(gnt1 & gnt2) == '0)
		else $error("prf: both selectors granted the same register");

	// retirement and recovery never overlap a pending result
	a_free_write_disjoint: assert property (@(posedge clock) disable iff (!rst_n)
		(free_vec & write_vec) == '0)
		else $error("prf: register freed and written in the same cycle");

endmodule

`default_nettype wire

/* verilog/rename_regfile_top.sv */
`default_nettype none
`timescale 1ns/1ps

module rename_regfile_top
	import prf_pkg::*;
(
	input  logic               clock,
	input  logic               rst_n,
	// rename side, one strobe per slot of each thread
	input  logic [3:0]         alloc_req,
	output alloc_grant_t [3:0] grant,
	// results from the functional units
	input  cdb_t               cdb1,
	input  cdb_t               cdb2,
	// operand fetch for the two dispatching instructions
	input  rd_req_t [3:0]      rd_req,
	output rd_rsp_t [3:0]      rd_rsp,
	// retirement of one instruction per thread
	input  retire_free_t       retire1,
	input  retire_free_t       retire2,
	// mispredict recovery per thread
	input  flush_free_t        flush1,
	input  flush_free_t        flush2
);

	// the shared register file is the only block at this level for now
	prf u_prf (
		.clock    (clock),
		.rst_n    (rst_n),
		.alloc_req(alloc_req),
		.grant    (grant),
		.cdb1     (cdb1),
		.cdb2     (cdb2),
		.rd_req   (rd_req),
		.rd_rsp   (rd_rsp),
		.retire1  (retire1),
		.retire2  (retire2),
		.flush1   (flush1),
		.flush2   (flush2)
	);

endmodule

`default_nettype wire

/* sim/tb_rename_regfile.sv */
`default_nettype none
`timescale 1ns/1ps

`include "prf_config.svh"

module tb_rename_regfile
	import prf_pkg::*;
();

	localparam int EDGE_TIMEOUT = 200;	// ns allowed before the next falling edge must show up

	logic               clock;
	logic               rst_n;
	logic [3:0]         alloc_req;
	alloc_grant_t [3:0] grant;
	cdb_t               cdb1;
	cdb_t               cdb2;
	rd_req_t [3:0]      rd_req;
	rd_rsp_t [3:0]      rd_rsp;
	retire_free_t       retire1;
	retire_free_t       retire2;
	flush_free_t        flush1;
	flush_free_t        flush2;

	integer seed = 32'h536079b3;
	int     errors = 0;
	int     checks = 0;

	// reference state of every physical register
	logic      ref_free  [`PRF_SIZE];
	logic      ref_ready [`PRF_SIZE];
	prf_data_t ref_data  [`PRF_SIZE];

	rename_regfile_top dut0 (
		.clock    (clock),
		.rst_n    (rst_n),
		.alloc_req(alloc_req),
		.grant    (grant),
		.cdb1     (cdb1),
		.cdb2     (cdb2),
		.rd_req   (rd_req),
		.rd_rsp   (rd_rsp),
		.retire1  (retire1),
		.retire2  (retire2),
		.flush1   (flush1),
		.flush2   (flush2)
	);

	always #50 clock = ~clock;	// 100 ns period

	//////////////////////////////
	// reference model
	//////////////////////////////

	// the first two asserted requesters get the two lowest free entries, in that order
	function automatic alloc_grant_t expected_grant(input logic [3:0] req, input int r);
		alloc_grant_t g;
		int           rank;
		int           first_free;
		int           second_free;
		g           = '0;
		rank        = 0;
		first_free  = -1;
		second_free = -1;
		for (int i = 0; i < `PRF_SIZE; i++)
		begin
			if (ref_free[i] && first_free < 0)
				first_free = i;
			else if (ref_free[i] && second_free < 0)
				second_free = i;
		end
		for (int k = 0; k < r; k++)
		begin
			if (req[k])
				rank++;	// requesters ahead of this one
		end
		if (req[r] && rank == 0 && first_free >= 0)
		begin
			g.valid = 1'b1;
			g.tag   = prf_tag_t'(first_free);
		end
		else if (req[r] && rank == 1 && second_free >= 0)
		begin
			g.valid = 1'b1;
			g.tag   = prf_tag_t'(second_free);
		end
		return g;
	endfunction

	// an operand is there only once the register is in use and written
	function automatic rd_rsp_t expected_read(input prf_tag_t tag);
		rd_rsp_t rsp;
		rsp = '0;
		if (ref_ready[tag] && !ref_free[tag])
		begin
			rsp.valid = 1'b1;
			rsp.data  = ref_data[tag];
		end
		return rsp;
	endfunction

	// model moves on the same edge as the register file
	always @(posedge clock)
	begin
		logic [`PRF_SIZE-1:0] taken;
		logic [`PRF_SIZE-1:0] released;
		alloc_grant_t         g;
		if (!rst_n)
		begin
			for (int i = 0; i < `PRF_SIZE; i++)
			begin
				ref_free[i]  = 1'b1;
				ref_ready[i] = 1'b0;
				ref_data[i]  = '0;
			end
		end
		else
		begin
			taken = '0;
			for (int r = 0; r < 4; r++)
			begin
				g = expected_grant(alloc_req, r);
				if (g.valid)
					taken[g.tag] = 1'b1;
			end
			released = '0;
			if (retire1.valid)
				released[retire1.tag] = 1'b1;
			if (retire2.valid)
				released[retire2.tag] = 1'b1;
			if (flush1.valid)
				released = released | (flush1.rrat_free_list & flush1.rat_free_list);
			if (flush2.valid)
				released = released | (flush2.rrat_free_list & flush2.rat_free_list);
			for (int i = 0; i < `PRF_SIZE; i++)
			begin
				if (released[i])
				begin
					ref_free[i]  = 1'b1;	// release beats everything else
					ref_ready[i] = 1'b0;
				end
				else if (taken[i])
				begin
					ref_free[i]  = 1'b0;
					ref_ready[i] = 1'b0;
				end
				else if (cdb2.valid && int'(cdb2.tag) == i)
				begin
					ref_ready[i] = 1'b1;	// cdb2 wins a shared tag
					ref_data[i]  = cdb2.data;
				end
				else if (cdb1.valid && int'(cdb1.tag) == i)
				begin
					ref_ready[i] = 1'b1;
					ref_data[i]  = cdb1.data;
				end
			end
		end
	end

	//////////////////////////////
	// checking
	//////////////////////////////

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// outputs are combinational, so they have long settled 40 ns after the stimulus
	always @(negedge clock)
	begin
		alloc_grant_t eg;
		rd_rsp_t      er;
		#40;
		if (rst_n)
		begin
			for (int r = 0; r < 4; r++)
			begin
				eg = expected_grant(alloc_req, r);
				check_value($sformatf("grant[%0d].valid", r), 64'(grant[r].valid), 64'(eg.valid));
				if (eg.valid)
					check_value($sformatf("grant[%0d].tag", r), 64'(grant[r].tag), 64'(eg.tag));
			end
			for (int p = 0; p < 4; p++)
			begin
				er = expected_read(rd_req[p].tag);
				check_value($sformatf("rd_rsp[%0d].valid", p), 64'(rd_rsp[p].valid), 64'(er.valid));
				check_value($sformatf("rd_rsp[%0d].data", p), rd_rsp[p].data, er.data);	// zero when invalid
			end
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	// polls land half a nanosecond off the clock grid, so an edge is never shared
	task automatic wait_fall();
		int spins;
		spins = 0;
		while (clock !== 1'b1 && spins < EDGE_TIMEOUT)
		begin
			#1;
			spins++;
		end
		while (clock !== 1'b0 && spins < EDGE_TIMEOUT)
		begin
			#1;
			spins++;
		end
		if (spins >= EDGE_TIMEOUT)
		begin
			$display("timeout: no falling clock edge seen within %0d ns", EDGE_TIMEOUT);
			$display("Result: FAILED");
			$finish;
		end
	endtask

	// every cycle starts idle with four random operand reads
	task automatic next_cycle();
		wait_fall();
		alloc_req = '0;
		cdb1      = '0;
		cdb2      = '0;
		retire1   = '0;
		retire2   = '0;
		flush1    = '0;
		flush2    = '0;
		for (int p = 0; p < 4; p++)
			rd_req[p].tag = prf_tag_t'($random(seed));
	endtask

	function automatic cdb_t make_result(input int tag);
		cdb_t bus;
		bus.valid = 1'b1;
		bus.tag   = prf_tag_t'(tag);
		bus.data  = {$random(seed), $random(seed)};
		return bus;
	endfunction

	// first register in use at or after start, -1 when every register is free
	function automatic int pick_busy(input int start);
		int idx;
		for (int k = 0; k < `PRF_SIZE; k++)
		begin
			idx = (start + k) % `PRF_SIZE;
			if (!ref_free[idx])
				return idx;
		end
		return -1;
	endfunction

	initial
	begin
		int busy;
		clock     = 1'b0;
		rst_n     = 1'b0;
		alloc_req = '0;
		cdb1      = '0;
		cdb2      = '0;
		rd_req    = '0;
		retire1   = '0;
		retire2   = '0;
		flush1    = '0;
		flush2    = '0;
		#0.5;
		for (int i = 0; i < 3; i++)
			wait_fall();
		rst_n = 1'b1;

		next_cycle();
		alloc_req = 4'b0001;	// lone request right after reset, entry 0 expected
		for (int c = 0; c < 40; c++)
		begin
			next_cycle();
			alloc_req = 4'($random(seed));
		end
		// drain whatever is left so the pool runs dry
		for (int c = 0; c < 18; c++)
		begin
			next_cycle();
			alloc_req = 4'b1111;
		end
		for (int c = 0; c < 4; c++)
			next_cycle();	// everything allocated, nothing written yet

		// results for every register, two per cycle
		for (int t = 0; t < `PRF_SIZE; t += 2)
		begin
			next_cycle();
			cdb1 = make_result(t);
			cdb2 = make_result(t + 1);
		end
		next_cycle();
		cdb1 = make_result(5);
		cdb2 = make_result(5);	// same tag on both buses
		next_cycle();
		rd_req[0].tag = prf_tag_t'(5);
		rd_req[1].tag = prf_tag_t'(30);
		rd_req[2].tag = prf_tag_t'(31);

		// retirement hands 7 and 20 back to the pool
		next_cycle();
		retire1.valid = 1'b1;
		retire1.tag   = prf_tag_t'(7);
		retire2.valid = 1'b1;
		retire2.tag   = prf_tag_t'(20);
		next_cycle();
		alloc_req     = 4'b0010;
		rd_req[0].tag = prf_tag_t'(20);
		next_cycle();
		alloc_req = 4'b1000;

		// recovery of each thread, then take the released entries again
		next_cycle();
		flush1.valid          = 1'b1;
		flush1.rrat_free_list = prf_vec_t'($random(seed));
		flush1.rat_free_list  = prf_vec_t'($random(seed));
		next_cycle();
		flush2.valid          = 1'b1;
		flush2.rrat_free_list = prf_vec_t'($random(seed));
		flush2.rat_free_list  = prf_vec_t'($random(seed));
		for (int c = 0; c < 14; c++)
		begin
			next_cycle();
			alloc_req = 4'b1111;
		end

		// mixed traffic, a write never lands on a register retiring in the same cycle
		for (int c = 0; c < 60; c++)
		begin
			next_cycle();
			alloc_req = 4'($random(seed));
			if ($random(seed) & 1)
			begin
				retire1.valid = 1'b1;
				retire1.tag   = prf_tag_t'($random(seed));
			end
			busy = pick_busy($random(seed) & 31);
			if (busy >= 0 && !(retire1.valid && int'(retire1.tag) == busy))
				cdb1 = make_result(busy);
		end
		next_cycle();
		wait_fall();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/prf_pkg.sv
prf/prf_one_entry.sv
prf/priority_selector.sv
prf/prf_read_port.sv
prf/prf.sv
verilog/rename_regfile_top.sv
sim/tb_rename_regfile.sv

/* Makefile */
# Verilator build and run of the shared physical register file testbench

TOP := tb_rename_regfile

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f src.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
